// ==== Makefile ====
SIM := obj_dir/Vtb_rv_id_stage

$(SIM): rv_id_stage.f $(wildcard src/*.sv) $(wildcard bench/*.sv)
	verilator --binary -Wno-fatal --top-module tb_rv_id_stage -f rv_id_stage.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== bench/tb_rv_id_stage.sv ====
// testbench stands in for fetch, execute and writeback; the stage must be empty between table rows
`timescale 1ns/10ps

module tb_rv_id_stage
  import rv_id_pkg::*;
();

  localparam int PERIOD      = 20;
  localparam int RST_CYCLES  = 10;
  localparam int N_ROWS      = 28;
  localparam int WATCHDOG_NS = (N_ROWS * 20 + RST_CYCLES) * PERIOD;

  typedef struct packed {
    logic [31:0] inst;
    logic [5:0]  wr;      // {en, addr} of a writeback before the row
    logic [14:0] byp_rd;  // execute, memory, writeback
    logic        load;
    logic [3:0]  hold;    // cycles with execute not accepting
    logic [4:0]  rd;
    logic [63:0] imm;
    ctrl_t       ctrl;
  } row_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       fs_valid;
  fetch_pkt_t fs_pkt;
  logic       ds_allowin;
  logic       es_valid;
  ds_to_es_t  ds_out;
  logic       es_allowin;
  redirect_t  redirect;
  wb_t        wb;
  bypass_t    es_byp;
  bypass_t    ms_byp;
  bypass_t    ws_byp;
  logic       es_load;

  row_t        rows [N_ROWS];
  int          n_rows = 0;
  logic [63:0] shadow [32];
  logic [4:0]  byp_rd [3];
  logic [63:0] byp_val [3];
  logic [31:0] lcg_state = 32'h1b76;
  int          errors = 0;
  int          rows_ok = 0;
  int          rows_bad = 0;

  rv_id_stage rv_id_stage_i (
    .i_clk            (clk),
    .i_rst            (rst),
    .i_fs_valid       (fs_valid),
    .i_fs_pkt         (fs_pkt),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (es_valid),
    .o_ds_to_es       (ds_out),
    .i_es_allowin     (es_allowin),
    .o_redirect       (redirect),
    .i_wb             (wb),
    .i_es_byp         (es_byp),
    .i_ms_byp         (ms_byp),
    .i_ws_byp         (ws_byp),
    .i_es_load        (es_load)
  );

  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [63:0] next_rand();
    logic [31:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state};
  endfunction

  // flags are {word, gpr_wen, mem_ren, mem_wen, invalid}
  function automatic ctrl_t ctrl_word(input logic [1:0] s1, input logic s2, input logic [3:0] alu,
                                      input logic [4:0] flags, input logic [2:0] mop,
                                      input logic [3:0] br);
    return ctrl_t'({s1, s2, alu, flags[4:1], mop, br, flags[0]});
  endfunction

  function automatic ctrl_t br_ctrl(input logic [3:0] br);
    return ctrl_word(2'd0, 1'b0, 4'h0, 5'b00000, 3'd0, br);
  endfunction

  task automatic table_row(input logic [31:0] inst, input logic [5:0] wr, input logic [14:0] rd3,
                           input logic load, input logic [3:0] hold, input logic [4:0] rd,
                           input logic [63:0] imm, input ctrl_t ctrl);
    rows[n_rows] = {inst, wr, rd3, load, hold, rd, imm, ctrl};
    n_rows++;
  endtask

  // register sources by format, unused ones read as x0
  function automatic void source_regs(input logic [31:0] inst, output logic [4:0] rs1,
                                      output logic [4:0] rs2);
    logic [6:0] opc;
    opc = inst[6:0];
    rs1 = (opc inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP,
                       OPC_OP_IMM32, OPC_OP32}) ? inst[19:15] : 5'd0;
    rs2 = (opc inside {OPC_BRANCH, OPC_STORE, OPC_OP, OPC_OP32}) ? inst[24:20] : 5'd0;
  endfunction

  function automatic logic [63:0] expect_operand(input logic [4:0] rs);
    for (int s = 0; s < 3; s++) begin
      if (byp_rd[s] != 5'd0 && byp_rd[s] == rs) return byp_val[s]; // youngest first
    end
    return shadow[rs];
  endfunction

  function automatic logic branch_taken(input logic [3:0] br, input logic [63:0] a,
                                        input logic [63:0] b);
    case (br)
      BR_BEQ:          return a == b;
      BR_BNE:          return a != b;
      BR_BLT:          return $signed(a) < $signed(b);
      BR_BGE:          return $signed(a) >= $signed(b);
      BR_BLTU:         return a < b;
      BR_BGEU:         return a >= b;
      BR_JAL, BR_JALR: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: no decode output after %0d ns, run stopped", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    row_t        row;
    ctrl_t       c_add;
    ds_to_es_t   snap;
    logic [63:0] pc;
    logic [63:0] wdata;
    logic [63:0] op1;
    logic [63:0] op2;
    logic [63:0] exp_target;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        exp_taken;
    logic        stall;
    int          err0;

    rst        = 1'b1;
    fs_valid   = 1'b0;
    fs_pkt     = '0;
    es_allowin = 1'b1;
    wb         = '0;
    es_byp     = '0;
    ms_byp     = '0;
    ws_byp     = '0;
    es_load    = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end

    c_add = ctrl_word(2'd0, 1'b0, 4'h0, 5'b01000, 3'd0, BR_NONE);
    // regfile, bypass priority, load-use
    table_row(32'h002081B3, 6'h00, 15'h0000, 1'b0, 4'd3, 5'd3, 64'd0, c_add);
    table_row(32'h002081B3, 6'h21, 15'h0000, 1'b0, 4'd0, 5'd3, 64'd0, c_add);
    table_row(32'h002001B3, 6'h20, 15'h0000, 1'b0, 4'd0, 5'd3, 64'd0, c_add);
    table_row(32'h002081B3, 6'h00, 15'h0421, 1'b0, 4'd0, 5'd3, 64'd0, c_add);
    table_row(32'h002081B3, 6'h00, 15'h0042, 1'b0, 4'd0, 5'd3, 64'd0, c_add);
    table_row(32'h002081B3, 6'h00, 15'h0001, 1'b0, 4'd0, 5'd3, 64'd0, c_add);
    table_row(32'h002081B3, 6'h00, 15'h0800, 1'b1, 4'd0, 5'd3, 64'd0, c_add);
    table_row(32'h0080B203, 6'h00, 15'h0400, 1'b1, 4'd0, 5'd4, 64'd8,
              ctrl_word(2'd0, 1'b1, 4'h0, 5'b01100, 3'd3, BR_NONE));
    // decode
    table_row(32'h123453B7, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd7, 64'h12345000,
              ctrl_word(2'd2, 1'b1, 4'h0, 5'b01000, 3'd0, BR_NONE));
    table_row(32'hFFFFF417, 6'h00, 15'h0000, 1'b0, 4'd2, 5'd8, 64'hFFFF_FFFF_FFFF_F000,
              ctrl_word(2'd1, 1'b1, 4'h0, 5'b01000, 3'd0, BR_NONE));
    table_row(32'hFE20BC23, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'hFFFF_FFFF_FFFF_FFF8,
              ctrl_word(2'd0, 1'b1, 4'h0, 5'b00010, 3'd3, BR_NONE));
    table_row(32'hFFF0849B, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd9, 64'hFFFF_FFFF_FFFF_FFFF,
              ctrl_word(2'd0, 1'b1, 4'h0, 5'b11000, 3'd0, BR_NONE));
    table_row(32'h402081B3, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd3, 64'd0,
              ctrl_word(2'd0, 1'b0, 4'h8, 5'b01000, 3'd0, BR_NONE));
    table_row(32'h0000007F, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd0,
              ctrl_word(2'd0, 1'b0, 4'h0, 5'b00001, 3'd0, BR_NONE));
    // branches on x5/x6, same register or both orders so each kind goes both ways
    table_row(32'h00528863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BEQ));
    table_row(32'h00628863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BEQ));
    table_row(32'h00629863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BNE));
    table_row(32'h00529863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BNE));
    table_row(32'h0062C863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BLT));
    table_row(32'h00534863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BLT));
    table_row(32'h0062D863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BGE));
    table_row(32'h00535863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BGE));
    table_row(32'h0062E863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BLTU));
    table_row(32'h00536863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BLTU));
    table_row(32'h0062F863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BGEU));
    table_row(32'h00537863, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd0, 64'd16, br_ctrl(BR_BGEU));
    table_row(32'h020000EF, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd1, 64'd32,
              ctrl_word(2'd1, 1'b0, 4'h0, 5'b01000, 3'd0, BR_JAL));
    table_row(32'h005380E7, 6'h00, 15'h0000, 1'b0, 4'd0, 5'd1, 64'd5,
              ctrl_word(2'd1, 1'b0, 4'h0, 5'b01000, 3'd0, BR_JALR));

    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    #1;
    check("reset allowin", ds_allowin, 1'b1);
    check("reset valid", es_valid, 1'b0);
    check("reset redirect", redirect.taken, 1'b0);
    $display("reset state %s", (errors == 0) ? "ok" : "FAILED");

    for (int i = 1; i < 32; i++) begin  // fill x1..x31
      @(negedge clk);
      wdata = next_rand();
      wb = {1'b1, i[4:0], wdata};
      @(posedge clk);
      shadow[i] = wdata;
    end
    @(negedge clk);
    wb.wen = 1'b0;

    for (int r = 0; r < N_ROWS; r++) begin
      err0 = errors;
      row  = rows[r];
      pc   = 64'h1000 + 64'(r) * 64'd64;
      if (row.wr[5]) begin
        wdata = next_rand();
        wb = {1'b1, row.wr[4:0], wdata};
        @(posedge clk);
        if (row.wr[4:0] != 5'd0) shadow[row.wr[4:0]] = wdata; // x0 stays zero
        @(negedge clk);
        wb.wen = 1'b0;
      end
      for (int s = 0; s < 3; s++) begin
        byp_rd[s]  = row.byp_rd[14 - 5 * s -: 5];
        byp_val[s] = next_rand();
      end
      es_byp     = {byp_rd[0], byp_val[0]};
      ms_byp     = {byp_rd[1], byp_val[1]};
      ws_byp     = {byp_rd[2], byp_val[2]};
      es_load    = row.load;
      es_allowin = (row.hold == 4'd0);
      fs_valid   = 1'b1;
      fs_pkt     = {row.inst, pc};

      source_regs(row.inst, rs1, rs2);
      op1        = expect_operand(rs1);
      op2        = expect_operand(rs2);
      exp_taken  = branch_taken(row.ctrl.br_func, op1, op2);
      exp_target = (row.ctrl.br_func == BR_JALR) ? ((op1 + row.imm) & ~64'd1) : pc + row.imm;
      stall      = row.load && byp_rd[0] != 5'd0 && (byp_rd[0] == rs1 || byp_rd[0] == rs2);

      #1;
      check("accept allowin", ds_allowin, 1'b1);
      @(negedge clk);
      fs_valid = 1'b0;
      if (stall) begin
        repeat (2) begin
          #1;
          check("stall valid", es_valid, 1'b0);
          check("stall allowin", ds_allowin, 1'b0);
          @(negedge clk);
        end
        es_load = 1'b0;
      end
      if (row.hold != 4'd0) begin
        fs_valid = 1'b1;   // next packet waits behind the held one
        fs_pkt   = {32'h009403B3, pc + 64'd4};
      end
      for (int c = 0; c < row.hold; c++) begin
        #1;
        if (c == 0) snap = ds_out;
        check("held valid", es_valid, 1'b1);
        check("held allowin", ds_allowin, 1'b0);
        check("held payload", ds_out == snap, 1'b1);
        @(negedge clk);
      end
      fs_valid   = 1'b0;
      es_allowin = 1'b1;
      if (exp_taken) begin
        fs_valid = 1'b1;   // wrong-path packet
        fs_pkt   = {32'h009403B3, pc + 64'd4};
      end

      #1;
      while (!es_valid) begin
        @(negedge clk);
        #1;
      end
      check("allowin", ds_allowin, 1'b1);
      check("rd", ds_out.rd, row.rd);
      check("imm", ds_out.imm, row.imm);
      check("ctrl", ds_out.ctrl, row.ctrl);
      check("rs1data", ds_out.rs1data, op1);
      check("rs2data", ds_out.rs2data, op2);
      check("pc", ds_out.pc, pc);
      check("redirect taken", redirect.taken, exp_taken);
      if (exp_taken) check("redirect target", redirect.target, exp_target);
      @(negedge clk);
      fs_valid = 1'b0;

      if (exp_taken) begin
        #1;
        check("nop valid", es_valid, 1'b1);
        check("nop rd", ds_out.rd, 5'd0);
        check("nop imm", ds_out.imm, 64'd0);
        check("nop gpr_wen", ds_out.ctrl.gpr_wen, 1'b1);
        check("nop mem access", {ds_out.ctrl.mem_ren, ds_out.ctrl.mem_wen}, 2'b00);
        check("nop pc", ds_out.pc, pc + 64'd4);
        @(negedge clk);
      end
      es_byp  = '0;
      ms_byp  = '0;
      ws_byp  = '0;
      es_load = 1'b0;

      if (errors == err0) rows_ok++;
      else rows_bad++;
      $display("row %0d inst %h pc %h %s", r, row.inst, pc, (errors == err0) ? "ok" : "FAILED");
    end

    $display("rows ok %0d, rows failed %0d, check errors %0d", rows_ok, rows_bad, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== rv_id_stage.f ====
src/rv_id_pkg.sv
src/gpr_file.sv
src/ds_pipe_reg.sv
src/inst_decoder.sv
src/operand_bypass.sv
src/branch_unit.sv
src/rv_id_stage.sv
bench/tb_rv_id_stage.sv

// ==== src/branch_unit.sv ====
// branch and jump resolution on forwarded operands. jal and jalr are always taken
`timescale 1ns/10ps

module branch_unit
  import rv_id_pkg::*;
(
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1data,
  input  logic [XLEN-1:0] i_rs2data,
  input  logic [XLEN-1:0] i_imm,
  input  br_func_e        i_br_func,
  output logic            o_taken,
  output logic [XLEN-1:0] o_target
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic [XLEN-1:0] jalr_sum;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  assign jalr_sum = i_rs1data + i_imm;

  always_comb begin
    case (i_br_func)
      BR_BEQ:          o_taken = eq;
      BR_BNE:          o_taken = ~eq;
      BR_BLT:          o_taken = lt;
      BR_BGE:          o_taken = ~lt;
      BR_BLTU:         o_taken = ltu;
      BR_BGEU:         o_taken = ~ltu;
      BR_JAL, BR_JALR: o_taken = 1'b1;
      default:         o_taken = 1'b0;
    endcase
  end

  assign o_target = (i_br_func == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} // lsb cleared
                                           : i_pc + i_imm;

endmodule

// ==== src/ds_pipe_reg.sv ====
// fetch-to-decode register. A packet accepted in a redirect cycle is kept as a nop with its own pc
`timescale 1ns/10ps

module ds_pipe_reg
  import rv_id_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_fs_valid,
  input  fetch_pkt_t i_fs_pkt,
  input  logic       i_es_allowin,
  input  logic       i_load_stall,
  input  logic       i_redirect_taken,
  output logic       o_ds_allowin,
  output logic       o_ds_valid_go,
  output fetch_pkt_t o_pkt
);

  logic ds_valid;
  logic ds_ready_go;

  assign ds_ready_go   = ~i_load_stall;
  assign o_ds_allowin  = ~ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_valid_go = ds_valid & ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  // held while stalled or back-pressured
  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_pkt.pc <= i_fs_pkt.pc;
      if (i_redirect_taken) begin
        o_pkt.inst <= NOP_INST; // wrong path
      end else begin
        o_pkt.inst <= i_fs_pkt.inst;
      end
    end
  end

endmodule

// ==== src/gpr_file.sv ====
// 31 x 64 register file with x0 tied to zero. Same-cycle write data is not forwarded here
`timescale 1ns/10ps

module gpr_file
  import rv_id_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [REG_ADDR_W-1:0] i_raddr1,
  input  logic [REG_ADDR_W-1:0] i_raddr2,
  output logic [XLEN-1:0]       o_rdata1,
  output logic [XLEN-1:0]       o_rdata2,
  input  wb_t                   i_wb
);

  logic [XLEN-1:0] regs [1:31]; // no storage for x0

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.waddr != '0) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== src/inst_decoder.sv ====
// RV64I decode for the kept opcode set only. Anything else is flagged invalid with all enables low
`timescale 1ns/10ps

module inst_decoder
  import rv_id_pkg::*;
(
  input  logic [INST_W-1:0]     i_inst,
  output logic [REG_ADDR_W-1:0] o_rs1,
  output logic [REG_ADDR_W-1:0] o_rs2,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic [XLEN-1:0]       o_imm,
  output ctrl_t                 o_ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            f7b5;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign f7b5   = i_inst[30];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_rs1  = i_inst[19:15];
    o_rs2  = '0;           // only read where the format has rs2
    o_rd   = i_inst[11:7];
    o_imm  = '0;
    o_ctrl = '0;
    o_ctrl.src1_sel = SRC1_REG;
    o_ctrl.src2_sel = SRC2_REG;
    o_ctrl.br_func  = BR_NONE;
    case (opcode)
      OPC_LUI: begin
        o_rs1 = '0;
        o_imm = imm_u;
        o_ctrl.src1_sel = SRC1_ZERO;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_rs1 = '0;
        o_imm = imm_u;
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // link value pc+4 is formed in execute from br_func
        if (opcode == OPC_JAL) begin
          o_rs1 = '0;
          o_imm = imm_j;
          o_ctrl.br_func = BR_JAL;
        end else begin
          o_imm = imm_i;
          o_ctrl.br_func = BR_JALR;
        end
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_BRANCH: begin
        o_rs2 = i_inst[24:20];
        o_rd  = '0;
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_ctrl.br_func = BR_BEQ;
          3'b001:  o_ctrl.br_func = BR_BNE;
          3'b100:  o_ctrl.br_func = BR_BLT;
          3'b101:  o_ctrl.br_func = BR_BGE;
          3'b110:  o_ctrl.br_func = BR_BLTU;
          3'b111:  o_ctrl.br_func = BR_BGEU;
          default: o_ctrl.invalid = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        o_imm = imm_i;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.mem_op   = funct3;
      end
      OPC_STORE: begin
        o_rs2 = i_inst[24:20];
        o_rd  = '0;
        o_imm = imm_s;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.mem_op   = funct3;
      end
      OPC_OP_IMM, OPC_OP_IMM32: begin
        o_imm = imm_i;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.alu_op   = {f7b5 & (funct3 == 3'b101), funct3}; // bit 30 only for srai
        o_ctrl.word_op  = (opcode == OPC_OP_IMM32);
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_OP, OPC_OP32: begin
        o_rs2 = i_inst[24:20];
        o_ctrl.alu_op  = {f7b5, funct3};
        o_ctrl.word_op = (opcode == OPC_OP32);
        o_ctrl.gpr_wen = 1'b1;
      end
      default: begin
        o_rs1 = '0;
        o_rd  = '0;
        o_ctrl.invalid = 1'b1;
      end
    endcase
  end

endmodule

// ==== src/operand_bypass.sv ====
// operand forwarding, youngest stage first. A load in execute cannot forward and stalls instead
`timescale 1ns/10ps

module operand_bypass
  import rv_id_pkg::*;
(
  input  logic [REG_ADDR_W-1:0] i_rs1,
  input  logic [REG_ADDR_W-1:0] i_rs2,
  input  logic [XLEN-1:0]       i_rf_rdata1,
  input  logic [XLEN-1:0]       i_rf_rdata2,
  input  bypass_t               i_es_byp,
  input  bypass_t               i_ms_byp,
  input  bypass_t               i_ws_byp,
  input  logic                  i_es_load,
  output logic [XLEN-1:0]       o_rs1data,
  output logic [XLEN-1:0]       o_rs2data,
  output logic                  o_load_stall
);

  function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] rs,
                                           input logic [XLEN-1:0] rf_data,
                                           input bypass_t es, input bypass_t ms,
                                           input bypass_t ws);
    if (es.rd != '0 && es.rd == rs) return es.result;
    else if (ms.rd != '0 && ms.rd == rs) return ms.result;
    else if (ws.rd != '0 && ws.rd == rs) return ws.result;
    else return rf_data;
  endfunction

  assign o_rs1data = pick(i_rs1, i_rf_rdata1, i_es_byp, i_ms_byp, i_ws_byp);
  assign o_rs2data = pick(i_rs2, i_rf_rdata2, i_es_byp, i_ms_byp, i_ws_byp);

  // load data only exists once it reaches mem
  assign o_load_stall = i_es_load && (i_es_byp.rd != '0) &&
                        ((i_es_byp.rd == i_rs1) || (i_es_byp.rd == i_rs2));

endmodule

// ==== src/rv_id_pkg.sv ====
// shared widths, opcodes and stage payload structs for the RV64I decode stage and its neighbours
package rv_id_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013; // addi x0,x0,0

  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP32     = 7'b0111011;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_func_e;

  typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_ZERO} src1_sel_e; // zero for lui
  typedef enum logic {SRC2_REG, SRC2_IMM} src2_sel_e;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fetch_pkt_t;

  // rd of zero means nothing offered
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
  } bypass_t;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wb_t;

  typedef struct packed {
    src1_sel_e  src1_sel;
    src2_sel_e  src2_sel;
    logic [3:0] alu_op;   // {funct7[5], funct3}
    logic       word_op;  // 32-bit result, sign extended
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;
    br_func_e   br_func;
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       rs1data;
    logic [XLEN-1:0]       rs2data;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
  } ds_to_es_t;

  typedef struct packed {
    logic            taken; // one-cycle strobe
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

// ==== src/rv_id_stage.sv ====
// decode stage top. Fetch must take o_redirect in the cycle it is strobed, there is no replay
`timescale 1ns/10ps

module rv_id_stage
  import rv_id_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  // fetch side
  input  logic       i_fs_valid,
  input  fetch_pkt_t i_fs_pkt,
  output logic       o_ds_allowin,
  // execute side
  output logic       o_ds_to_es_valid,
  output ds_to_es_t  o_ds_to_es,
  input  logic       i_es_allowin,
  output redirect_t  o_redirect,
  // writeback and bypass
  input  wb_t        i_wb,
  input  bypass_t    i_es_byp,
  input  bypass_t    i_ms_byp,
  input  bypass_t    i_ws_byp,
  input  logic       i_es_load
);

  fetch_pkt_t            ds_pkt;
  logic                  ds_valid_go;
  logic                  load_stall;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  ctrl_t                 ctrl;
  logic [XLEN-1:0]       rf_rdata1;
  logic [XLEN-1:0]       rf_rdata2;
  logic [XLEN-1:0]       rs1data;
  logic [XLEN-1:0]       rs2data;
  logic                  br_taken;
  logic [XLEN-1:0]       br_target;

  // redirect only fires with the branch leaving for execute
  assign o_redirect.taken  = ds_valid_go & i_es_allowin & br_taken;
  assign o_redirect.target = br_target;
  assign o_ds_to_es_valid  = ds_valid_go;

  always_comb begin
    o_ds_to_es.ctrl    = ctrl;
    o_ds_to_es.rs1data = rs1data;
    o_ds_to_es.rs2data = rs2data;
    o_ds_to_es.imm     = imm;
    o_ds_to_es.pc      = ds_pkt.pc;
    o_ds_to_es.rd      = rd;
  end

  ds_pipe_reg u_ds_pipe_reg (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_valid       (i_fs_valid),
    .i_fs_pkt         (i_fs_pkt),
    .i_es_allowin     (i_es_allowin),
    .i_load_stall     (load_stall),
    .i_redirect_taken (o_redirect.taken),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid_go    (ds_valid_go),
    .o_pkt            (ds_pkt)
  );

  inst_decoder u_inst_decoder (
    .i_inst (ds_pkt.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wb     (i_wb)
  );

  operand_bypass u_operand_bypass (
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rf_rdata1  (rf_rdata1),
    .i_rf_rdata2  (rf_rdata2),
    .i_es_byp     (i_es_byp),
    .i_ms_byp     (i_ms_byp),
    .i_ws_byp     (i_ws_byp),
    .i_es_load    (i_es_load),
    .o_rs1data    (rs1data),
    .o_rs2data    (rs2data),
    .o_load_stall (load_stall)
  );

  branch_unit u_branch_unit (
    .i_pc      (ds_pkt.pc),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_imm     (imm),
    .i_br_func (ctrl.br_func),
    .o_taken   (br_taken),
    .o_target  (br_target)
  );

endmodule
